//--- verilog/mmio_pkg.sv
// MMIO slice shared definitions
// Widths, load/store request and response structs, the machine timer
// register map and the interrupt vector and cause encodings
package mmio_pkg;

   // ------------------------------------------------------------
   // Widths and base types
   // ------------------------------------------------------------
   localparam int XLEN      = 32;                   // Data and address width
   localparam int TIME_W    = 64;                   // mtime and mtimecmp width
   localparam int MMR_OFS_W = 6;                    // Byte offset inside the timer window
   localparam int MMR_SPAN  = 64;                   // Timer window size in bytes

   typedef logic [XLEN-1:0] addr_t;
   typedef logic [XLEN-1:0] data_t;

   // Core side and external I/O side, full word accesses only
   typedef struct packed {
      addr_t addr;                                  // Byte address, word aligned
      logic  rd;                                    // Load
      logic  wr;                                    // Store
      data_t wr_data;                               // Store data
   } ls_req_t;

   typedef struct packed {
      data_t rd_data;                               // Load data, zero for a store
      logic  fault;                                 // Access error
   } ls_rsp_t;

   // Timer block access, offset already relative to the window base
   typedef struct packed {
      logic                 rd;
      logic                 wr;
      logic [MMR_OFS_W-1:0] offset;
      data_t                wr_data;
   } mmr_req_t;

   typedef struct packed {
      data_t rd_data;
      logic  fault;                                 // Unmapped or misaligned offset
   } mmr_rsp_t;

   // Timer register map
   localparam logic [MMR_OFS_W-1:0] OFS_MSIP        = 6'h00;
   localparam logic [MMR_OFS_W-1:0] OFS_MIE         = 6'h04;
   localparam logic [MMR_OFS_W-1:0] OFS_MTIMECMP_LO = 6'h08;
   localparam logic [MMR_OFS_W-1:0] OFS_MTIMECMP_HI = 6'h0C;
   localparam logic [MMR_OFS_W-1:0] OFS_MTIME_LO    = 6'h10;
   localparam logic [MMR_OFS_W-1:0] OFS_MTIME_HI    = 6'h14;

   // ------------------------------------------------------------
   // Interrupts
   // ------------------------------------------------------------
   typedef logic [2:0] irq_vec_t;                   // One bit per source
   localparam int IRQ_SW    = 0;
   localparam int IRQ_TIMER = 1;
   localparam int IRQ_EXT   = 2;

   typedef logic [3:0] cause_t;
   localparam cause_t CAUSE_NONE  = 4'd0;
   localparam cause_t CAUSE_SW    = 4'd3;           // Machine software interrupt
   localparam cause_t CAUSE_TIMER = 4'd7;           // Machine timer interrupt
   localparam cause_t CAUSE_EXT   = 4'd11;          // Machine external interrupt

endpackage

//--- verilog/ls_router.sv
`timescale 1ns/1ps
// Load/store router
// Takes one core load or store at a time and steers it either to the
// machine timer registers or to the external I/O bus. Both sides use a
// req/ack handshake where req stays high until its ack
module ls_router
#(
   parameter mmio_pkg::addr_t MMR_BASE = 32'h0200_0000   // Base of the timer window
)
(
   input  logic               clk_in,
   input  logic               rst_n,

   // Core side
   input  logic               core_req,                  // Held until core_ack
   input  mmio_pkg::ls_req_t  core_req_data,
   output logic               core_ack,                  // One cycle pulse
   output mmio_pkg::ls_rsp_t  core_rsp,

   // External I/O bus
   output logic               io_req,                    // Held until io_ack
   output mmio_pkg::ls_req_t  io_req_data,
   input  logic               io_ack,
   input  mmio_pkg::ls_rsp_t  io_rsp,

   // Timer registers, answered in the same cycle
   output logic               mmr_req,
   output mmio_pkg::mmr_req_t mmr_req_data,
   input  mmio_pkg::mmr_rsp_t mmr_rsp
);
   import mmio_pkg::*;

   typedef enum logic [1:0]
   {
      ST_IDLE,                                           // Waiting for core_req
      ST_MMR,                                            // Timer answer on core_rsp
      ST_EXT,                                            // External access in flight
      ST_DONE                                            // One cycle gap after core_ack
   } state_t;

   state_t state;
   addr_t  win_ofs;                                      // Address relative to MMR_BASE
   logic   mmr_hit;
   logic   accept;
   logic   io_done;

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   // Unsigned subtract, anything below the base wraps to a large value
   assign win_ofs = core_req_data.addr - MMR_BASE;
   assign mmr_hit = (win_ofs < addr_t'(MMR_SPAN));
   assign accept  = (state == ST_IDLE) && core_req;
   assign io_done = (state == ST_EXT) && io_req && io_ack;

   // Timer access goes out in the accepting cycle
   assign mmr_req              = accept && mmr_hit;
   assign mmr_req_data.rd      = core_req_data.rd;
   assign mmr_req_data.wr      = core_req_data.wr;
   assign mmr_req_data.offset  = win_ofs[MMR_OFS_W-1:0];   // Window is 64 bytes
   assign mmr_req_data.wr_data = core_req_data.wr_data;

   // ------------------------------------------------------------
   // Control FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state    <= ST_IDLE;
         core_ack <= 1'b0;
         io_req   <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (accept && mmr_hit)
               begin
                  core_ack <= 1'b1;                      // Timer answered this cycle
                  state    <= ST_MMR;
               end
               else if (accept)
               begin
                  io_req <= 1'b1;                        // Out on the bus next cycle
                  state  <= ST_EXT;
               end
            end
            ST_MMR:
            begin
               core_ack <= 1'b0;
               state    <= ST_DONE;
            end
            ST_EXT:
            begin
               // Same state covers the wait and the ack cycle
               if (core_ack)
               begin
                  core_ack <= 1'b0;
                  state    <= ST_DONE;
               end
               else if (io_done)
               begin
                  io_req   <= 1'b0;
                  core_ack <= 1'b1;
               end
            end
            default: state <= ST_IDLE;                   // Gap so a held req is not retaken
         endcase
      end
   end

   // ------------------------------------------------------------
   // Request and response holding registers
   // ------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (accept && !mmr_hit)
         io_req_data <= core_req_data;                   // Stable while io_req is high

      if (mmr_req)
      begin
         core_rsp.rd_data <= mmr_rsp.rd_data;
         core_rsp.fault   <= mmr_rsp.fault;
      end
      else if (io_done)
      begin
         core_rsp.rd_data <= io_req_data.wr ? '0 : io_rsp.rd_data;   // Stores return zero
         core_rsp.fault   <= io_rsp.fault;
      end
   end

endmodule

//--- verilog/mmr_timer.sv
`timescale 1ns/1ps
// Machine timer register block
// Holds msip, the interrupt enables, mtimecmp and a prescaled mtime.
// Register reads are answered combinationally, writes land on the clock
// edge. Drives the software and timer interrupt sources
module mmr_timer
#(
   parameter int TIMER_DIV = 4                           // Clocks per mtime increment
)
(
   input  logic               clk_in,
   input  logic               rst_n,

   input  logic               mmr_req,                   // One cycle access strobe
   input  mmio_pkg::mmr_req_t mmr_req_data,
   output mmio_pkg::mmr_rsp_t mmr_rsp,

   output mmio_pkg::irq_vec_t irq_src,                   // Software and timer sources
   output mmio_pkg::irq_vec_t irq_en                     // Enable bits from mie
);
   import mmio_pkg::*;

   localparam int PS_W = $clog2(TIMER_DIV + 1);          // Wide enough for TIMER_DIV of 1

   logic [PS_W-1:0]   ps_cnt;                            // Prescaler
   logic              tick;                              // mtime advances this cycle
   logic [TIME_W-1:0] mtime;
   logic [TIME_W-1:0] mtime_inc;
   logic [TIME_W-1:0] mtimecmp;
   logic              msip;
   irq_vec_t          mie;

   logic              reg_hit;                           // Offset names a register
   data_t             rd_value;
   data_t             wdata;
   logic              wr_en;

   // ------------------------------------------------------------
   // Offset decode and read mux
   // ------------------------------------------------------------
   always_comb
   begin
      reg_hit  = 1'b1;
      rd_value = '0;
      case (mmr_req_data.offset)
         OFS_MSIP:        rd_value = data_t'(msip);
         OFS_MIE:         rd_value = data_t'(mie);
         OFS_MTIMECMP_LO: rd_value = mtimecmp[XLEN-1:0];
         OFS_MTIMECMP_HI: rd_value = mtimecmp[TIME_W-1:XLEN];
         OFS_MTIME_LO:    rd_value = mtime[XLEN-1:0];
         OFS_MTIME_HI:    rd_value = mtime[TIME_W-1:XLEN];
         default:         reg_hit  = 1'b0;              // Unmapped or misaligned
      endcase
   end

   assign wdata = mmr_req_data.wr_data;
   assign wr_en = mmr_req && mmr_req_data.wr && reg_hit;   // Faulting writes are dropped

   // Zero data on a fault or a store
   assign mmr_rsp.rd_data = (mmr_req && mmr_req_data.rd && reg_hit) ? rd_value : '0;
   assign mmr_rsp.fault   = mmr_req && !reg_hit;

   // ------------------------------------------------------------
   // Prescaler and mtime
   // ------------------------------------------------------------
   assign tick      = (ps_cnt == PS_W'(TIMER_DIV - 1));
   assign mtime_inc = mtime + TIME_W'(tick);

   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         ps_cnt <= '0;
      else if (tick)
         ps_cnt <= '0;
      else
         ps_cnt <= ps_cnt + 1'b1;
   end

   // A half write replaces that half, the other half keeps counting
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         mtime <= '0;
      else if (wr_en && (mmr_req_data.offset == OFS_MTIME_LO))
         mtime <= {mtime_inc[TIME_W-1:XLEN], wdata};
      else if (wr_en && (mmr_req_data.offset == OFS_MTIME_HI))
         mtime <= {wdata, mtime_inc[XLEN-1:0]};
      else
         mtime <= mtime_inc;
   end

   // ------------------------------------------------------------
   // Compare, software interrupt and enable registers
   // ------------------------------------------------------------
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mtimecmp <= '1;                                 // No timer interrupt out of reset
         msip     <= 1'b0;
         mie      <= '0;
      end
      else if (wr_en)
      begin
         case (mmr_req_data.offset)
            OFS_MSIP:        msip                    <= wdata[0];
            OFS_MIE:         mie                     <= wdata[$bits(irq_vec_t)-1:0];
            OFS_MTIMECMP_LO: mtimecmp[XLEN-1:0]      <= wdata;
            OFS_MTIMECMP_HI: mtimecmp[TIME_W-1:XLEN] <= wdata;
            default:         msip                    <= msip;   // mtime handled above
         endcase
      end
   end

   // Interrupt sources, external bit belongs to the interrupt controller
   assign irq_src[IRQ_SW]    = msip;
   assign irq_src[IRQ_TIMER] = (mtime >= mtimecmp);
   assign irq_src[IRQ_EXT]   = 1'b0;
   assign irq_en             = mie;

endmodule

//--- verilog/irq_ctrl.sv
`timescale 1ns/1ps
// Interrupt controller
// Merges the external interrupt with the timer block sources, masks them
// with the enables, picks the cause by priority and keeps the sleep state
module irq_ctrl
(
   input  logic               clk_in,
   input  logic               rst_n,

   input  mmio_pkg::irq_vec_t irq_src,                   // Software and timer sources
   input  mmio_pkg::irq_vec_t irq_en,                    // Per source enables
   input  logic               ext_irq,                   // External interrupt line
   input  logic               wfi,                       // One cycle wait-for-interrupt

   output mmio_pkg::irq_vec_t irq_pending,
   output mmio_pkg::cause_t   irq_cause,
   output logic               sleeping
);
   import mmio_pkg::*;

   irq_vec_t src_all;                                    // All three sources
   logic     any_pending;

   // ------------------------------------------------------------
   // Masking and cause priority
   // ------------------------------------------------------------
   assign src_all     = irq_src | irq_vec_t'(ext_irq << IRQ_EXT);
   assign irq_pending = src_all & irq_en;
   assign any_pending = |irq_pending;

   // External first, then timer, then software
   always_comb
   begin
      if (irq_pending[IRQ_EXT])
         irq_cause = CAUSE_EXT;
      else if (irq_pending[IRQ_TIMER])
         irq_cause = CAUSE_TIMER;
      else if (irq_pending[IRQ_SW])
         irq_cause = CAUSE_SW;
      else
         irq_cause = CAUSE_NONE;
   end

   // ------------------------------------------------------------
   // Sleep state
   // ------------------------------------------------------------
   // Any enabled pending interrupt wakes the core, and it also
   // wins over a wfi in the same cycle
   always_ff @(posedge clk_in or negedge rst_n)
   begin
      if (!rst_n)
         sleeping <= 1'b0;
      else if (any_pending)
         sleeping <= 1'b0;
      else if (wfi)
         sleeping <= 1'b1;                               // Stay asleep until woken
   end

endmodule

//--- verilog/mmio_top.sv
`timescale 1ns/1ps
// MMIO slice top level
// Load/store router, machine timer registers and interrupt controller
module mmio_top
#(
   parameter mmio_pkg::addr_t MMR_BASE  = 32'h0200_0000, // Timer window base
   parameter int              TIMER_DIV = 4              // Clocks per mtime tick
)
(
   input  logic               clk_in,
   input  logic               rst_n,

   // Core load/store port
   input  logic               core_req,
   input  mmio_pkg::ls_req_t  core_req_data,
   output logic               core_ack,
   output mmio_pkg::ls_rsp_t  core_rsp,

   // External I/O bus
   output logic               io_req,
   output mmio_pkg::ls_req_t  io_req_data,
   input  logic               io_ack,
   input  mmio_pkg::ls_rsp_t  io_rsp,

   // Interrupts and sleep
   input  logic               ext_irq,
   input  logic               wfi,
   output mmio_pkg::irq_vec_t irq_pending,
   output mmio_pkg::cause_t   irq_cause,
   output logic               sleeping
);
   import mmio_pkg::*;

   logic     mmr_req;                                    // Router to timer strobe
   mmr_req_t mmr_req_data;
   mmr_rsp_t mmr_rsp;
   irq_vec_t irq_src;                                    // Timer block sources
   irq_vec_t irq_en;                                     // mie contents

   // ------------------------------------------------------------
   // Load/store routing
   // ------------------------------------------------------------
   ls_router #(.MMR_BASE(MMR_BASE)) i_router
   (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .core_req      (core_req),
      .core_req_data (core_req_data),
      .core_ack      (core_ack),
      .core_rsp      (core_rsp),
      .io_req        (io_req),                           // External bus master side
      .io_req_data   (io_req_data),
      .io_ack        (io_ack),
      .io_rsp        (io_rsp),
      .mmr_req       (mmr_req),
      .mmr_req_data  (mmr_req_data),
      .mmr_rsp       (mmr_rsp)
   );

   // Timer registers and interrupt sources
   mmr_timer #(.TIMER_DIV(TIMER_DIV)) i_timer
   (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .mmr_req       (mmr_req),
      .mmr_req_data  (mmr_req_data),
      .mmr_rsp       (mmr_rsp),
      .irq_src       (irq_src),
      .irq_en        (irq_en)
   );

   irq_ctrl i_irq_ctrl
   (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .irq_src       (irq_src),
      .irq_en        (irq_en),
      .ext_irq       (ext_irq),
      .wfi           (wfi),
      .irq_pending   (irq_pending),
      .irq_cause     (irq_cause),
      .sleeping      (sleeping)
   );

endmodule

//--- tb/tb_checks.svh
// Testbench compare tasks
// One task per kind of DUT result, each with its own error counter
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int rsp_errs   = 0;                                      // core_rsp data or fault
int cause_errs = 0;
int pend_errs  = 0;                                      // Masked interrupt vector
int sleep_errs = 0;
int mtime_errs = 0;                                      // mtime out of its allowed range
int misc_errs  = 0;                                      // Routing mistakes on the I/O bus

// Load/store response, data and fault compared separately
task automatic check_rsp(input ls_rsp_t got, input ls_rsp_t exp);
   if (got.rd_data !== exp.rd_data)
   begin
      $display("FAIL t=%0t core_rsp.rd_data got %h expected %h", $time, got.rd_data, exp.rd_data);
      rsp_errs++;
   end
   if (got.fault !== exp.fault)
   begin
      $display("FAIL t=%0t core_rsp.fault got %b expected %b", $time, got.fault, exp.fault);
      rsp_errs++;
   end
endtask

task automatic check_cause(input cause_t got, input cause_t exp);
   if (got !== exp)
   begin
      $display("FAIL t=%0t irq_cause got %0d expected %0d", $time, got, exp);
      cause_errs++;
   end
endtask

task automatic check_pending(input irq_vec_t got, input irq_vec_t exp);
   if (got !== exp)
   begin
      $display("FAIL t=%0t irq_pending got %b expected %b", $time, got, exp);
      pend_errs++;
   end
endtask

task automatic check_sleep(input logic got, input logic exp);
   if (got !== exp)
   begin
      $display("FAIL t=%0t sleeping got %b expected %b", $time, got, exp);
      sleep_errs++;
   end
endtask

// Low half of mtime must lie inside [lo, hi]
task automatic check_mtime(input data_t got, input data_t lo, input data_t hi);
   if ((got < lo) || (got > hi))
   begin
      $display("FAIL t=%0t mtime_lo got %h expected %h to %h", $time, got, lo, hi);
      mtime_errs++;
   end
endtask

`endif

//--- tb/tb_mmio_top.sv
`timescale 1ns/1ps
// Testbench for the MMIO slice top level
// Steps through a table of loads, stores, interrupt and sleep events,
// with a randomly delayed device model answering the external I/O bus
module tb_mmio_top;
   import mmio_pkg::*;

   localparam addr_t MMR_BASE      = 32'h0200_0000;
   localparam int    TIMER_DIV     = 4;
   localparam addr_t FAULT_ADDR    = 32'h1000_0FF0;     // Device faults this word
   localparam data_t FILL_KEY      = 32'h5A5A_A5A5;     // Unwritten words read addr ^ key
   localparam int    SEED          = 80230;
   localparam int    CYC_PER_ENTRY = 40;                // Watchdog budget per table step

   typedef enum logic [2:0]
   {
      OP_WR,                                            // Store, check response
      OP_RD,                                            // Load, check response
      OP_TIME,                                          // Load mtime_lo, check its range
      OP_EXT,                                           // Set ext_irq to wdata[0]
      OP_WFI                                            // One cycle wfi pulse
   } op_t;

   typedef struct packed {
      op_t      op;
      addr_t    addr;
      data_t    wdata;
      data_t    exp_data;
      logic     exp_fault;
      cause_t   exp_cause;                              // Cause after the step
      irq_vec_t exp_pend;                               // Enabled sources after the step
      logic     exp_sleep;
   } entry_t;

   logic        clk_in        = 1'b0;
   logic        rst_n         = 1'b0;
   logic        core_req      = 1'b0;
   ls_req_t     core_req_data = '0;
   logic        core_ack;
   ls_rsp_t     core_rsp;
   logic        io_req;
   ls_req_t     io_req_data;
   logic        io_ack        = 1'b0;
   ls_rsp_t     io_rsp        = '0;
   logic        ext_irq       = 1'b0;
   logic        wfi           = 1'b0;
   irq_vec_t    irq_pending;
   cause_t      irq_cause;
   logic        sleeping;

   entry_t      tbl [$];                                // Stimulus table
   logic        table_ready = 1'b0;
   int unsigned cyc_cnt     = 0;

   `include "tb_checks.svh"

   always #2 clk_in = ~clk_in;                          // 4 ns period

   always @(posedge clk_in)
      cyc_cnt <= cyc_cnt + 1;

   mmio_top #(.MMR_BASE(MMR_BASE), .TIMER_DIV(TIMER_DIV)) i_dut
   (
      .clk_in        (clk_in),
      .rst_n         (rst_n),
      .core_req      (core_req),
      .core_req_data (core_req_data),
      .core_ack      (core_ack),
      .core_rsp      (core_rsp),
      .io_req        (io_req),
      .io_req_data   (io_req_data),
      .io_ack        (io_ack),
      .io_rsp        (io_rsp),
      .ext_irq       (ext_irq),
      .wfi           (wfi),
      .irq_pending   (irq_pending),
      .irq_cause     (irq_cause),
      .sleeping      (sleeping)
   );

   // ------------------------------------------------------------
   // External I/O device model
   // ------------------------------------------------------------
   data_t       ext_mem [addr_t];                       // Sparse word store
   logic        io_busy = 1'b0;
   int unsigned io_wait = 0;

   function automatic ls_rsp_t device_answer(input ls_req_t req);
      ls_rsp_t rsp;
      rsp.fault   = (req.addr == FAULT_ADDR);
      rsp.rd_data = '0;
      if (req.rd && !rsp.fault)
         rsp.rd_data = ext_mem.exists(req.addr) ? ext_mem[req.addr] : (req.addr ^ FILL_KEY);
      return rsp;
   endfunction

   always @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         io_ack  <= 1'b0;
         io_busy <= 1'b0;
      end
      else if (io_ack)
      begin
         io_ack  <= 1'b0;                               // Single cycle ack
         io_busy <= 1'b0;
      end
      else if (io_req && !io_busy)
      begin
         io_busy <= 1'b1;
         io_wait <= $urandom % 6;                       // 0 to 5 extra cycles
         if ((io_req_data.addr >= MMR_BASE) &&
             (io_req_data.addr <= MMR_BASE + addr_t'(MMR_SPAN - 1)))
         begin
            $display("ERROR: timer window address %h reached the external bus",
                     io_req_data.addr);
            misc_errs++;
         end
      end
      else if (io_busy && (io_wait != 0))
         io_wait <= io_wait - 1;
      else if (io_busy)
      begin
         io_ack <= 1'b1;
         io_rsp <= device_answer(io_req_data);
         if (io_req_data.wr && (io_req_data.addr != FAULT_ADDR))
            ext_mem[io_req_data.addr] = io_req_data.wr_data;
      end
   end

   // ------------------------------------------------------------
   // Table helpers
   // ------------------------------------------------------------
   function automatic addr_t reg_addr(input logic [MMR_OFS_W-1:0] ofs);
      return MMR_BASE + addr_t'(ofs);
   endfunction

   task automatic add_entry(input op_t op, input addr_t addr, input data_t wdata,
                            input data_t exp_data, input logic exp_fault,
                            input cause_t exp_cause, input irq_vec_t exp_pend,
                            input logic exp_sleep);
      entry_t e;
      e.op        = op;
      e.addr      = addr;
      e.wdata     = wdata;
      e.exp_data  = exp_data;
      e.exp_fault = exp_fault;
      e.exp_cause = exp_cause;
      e.exp_pend  = exp_pend;
      e.exp_sleep = exp_sleep;
      tbl.push_back(e);
   endtask

   // Drives one access and returns at the negedge where core_ack is seen
   task automatic run_access(input logic is_wr, input addr_t addr, input data_t wdata,
                             output ls_rsp_t rsp);
      ls_req_t req;
      req.addr    = addr;
      req.rd      = !is_wr;
      req.wr      = is_wr;
      req.wr_data = is_wr ? wdata : '0;
      @(posedge clk_in);
      core_req      <= 1'b1;
      core_req_data <= req;
      @(negedge clk_in);
      while (!core_ack)
         @(negedge clk_in);
      rsp = core_rsp;
   endtask

   task automatic build_table();
      // Timer registers, enables all clear
      add_entry(OP_WR, reg_addr(OFS_MSIP), 32'h1, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(OFS_MSIP), '0, 32'h1, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MSIP), 32'h0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h5, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(OFS_MIE), '0, 32'h5, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MTIMECMP_LO), 32'h1234_5678, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(OFS_MTIMECMP_LO), '0, 32'h1234_5678, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MTIMECMP_HI), 32'h0000_00AB, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(OFS_MTIMECMP_HI), '0, 32'h0000_00AB, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(6'h18), '0, '0, 1'b1, CAUSE_NONE, '0, 1'b0);   // Unmapped
      add_entry(OP_RD, reg_addr(6'h06), '0, '0, 1'b1, CAUSE_NONE, '0, 1'b0);   // Misaligned
      add_entry(OP_WR, reg_addr(6'h3C), 32'hFFFF_FFFF, '0, 1'b1, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(6'h02), 32'h1, '0, 1'b1, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, reg_addr(OFS_MSIP), '0, '0, 1'b0, CAUSE_NONE, '0, 1'b0); // Write dropped
      // mtime, first sample then a dozen external accesses then the second
      add_entry(OP_WR, reg_addr(OFS_MTIME_LO), 32'h0000_1000, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_TIME, '0, '0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, 32'h1000_0000, 32'hDEAD_BEEF, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, 32'h1000_0004, 32'h0123_4567, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, 32'h2000_0100, 32'hA5A5_0F0F, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      // Just below and just above the timer window
      add_entry(OP_WR, 32'h01FF_FFFC, 32'h5555_AAAA, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, 32'h0200_0040, 32'h0BAD_F00D, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h1000_0000, '0, 32'hDEAD_BEEF, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h1000_0004, '0, 32'h0123_4567, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h2000_0100, '0, 32'hA5A5_0F0F, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h01FF_FFFC, '0, 32'h5555_AAAA, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h0200_0040, '0, 32'h0BAD_F00D, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, 32'h1000_0100, '0, 32'h1000_0100 ^ FILL_KEY, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, FAULT_ADDR, 32'h1111_1111, '0, 1'b1, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_RD, FAULT_ADDR, '0, '0, 1'b1, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_TIME, '0, '0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      // Timer and software causes
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h2, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MTIMECMP_HI), 32'h0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MTIMECMP_LO), 32'h0, '0, 1'b0, CAUSE_TIMER, 3'b010, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h1, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MSIP), 32'h1, '0, 1'b0, CAUSE_SW, 3'b001, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      // Priority, external interrupt and sleep
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h7, '0, 1'b0, CAUSE_TIMER, 3'b011, 1'b0);
      add_entry(OP_EXT, '0, 32'h1, '0, 1'b0, CAUSE_EXT, 3'b111, 1'b0);
      add_entry(OP_EXT, '0, 32'h0, '0, 1'b0, CAUSE_TIMER, 3'b011, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WFI, '0, '0, '0, 1'b0, CAUSE_NONE, '0, 1'b1);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h4, '0, 1'b0, CAUSE_NONE, '0, 1'b1);
      add_entry(OP_EXT, '0, 32'h1, '0, 1'b0, CAUSE_EXT, 3'b100, 1'b0);     // Wakes the core
      add_entry(OP_EXT, '0, 32'h0, '0, 1'b0, CAUSE_NONE, '0, 1'b0);
      add_entry(OP_WR, reg_addr(OFS_MIE), 32'h1, '0, 1'b0, CAUSE_SW, 3'b001, 1'b0);
      add_entry(OP_WFI, '0, '0, '0, 1'b0, CAUSE_SW, 3'b001, 1'b0);         // Pending beats wfi
   endtask

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial
   begin
      entry_t      e;
      ls_rsp_t     rsp;
      ls_rsp_t     exp_rsp;
      data_t       ref_val;                             // Last known mtime_lo
      int unsigned ref_cyc;
      int unsigned elapsed;
      int unsigned ticks;                               // Whole prescaler periods elapsed
      int          total;

      void'($urandom(SEED));
      ref_val   = '0;
      ref_cyc   = 0;
      build_table();
      table_ready = 1'b1;
      repeat (8) @(posedge clk_in);
      rst_n <= 1'b1;

      foreach (tbl[i])
      begin
         e = tbl[i];
         case (e.op)
            OP_WR, OP_RD:
            begin
               run_access(e.op == OP_WR, e.addr, e.wdata, rsp);
               exp_rsp.rd_data = e.exp_data;
               exp_rsp.fault   = e.exp_fault;
               check_rsp(rsp, exp_rsp);
               if ((e.op == OP_WR) && (e.addr == reg_addr(OFS_MTIME_LO)))
               begin
                  ref_val = e.wdata;                    // Counting restarts here
                  ref_cyc = cyc_cnt;
               end
            end
            OP_TIME:
            begin
               run_access(1'b0, reg_addr(OFS_MTIME_LO), '0, rsp);
               elapsed = cyc_cnt - ref_cyc;
               ticks   = elapsed / TIMER_DIV;
               // One tick of slack each way for the prescaler phase
               check_mtime(rsp.rd_data, ref_val + data_t'((ticks > 0) ? ticks - 1 : 0),
                           ref_val + data_t'(ticks + 1));
               ref_val = rsp.rd_data;
               ref_cyc = cyc_cnt;
            end
            OP_EXT:
            begin
               @(posedge clk_in);
               ext_irq <= e.wdata[0];
               repeat (2) @(negedge clk_in);            // Wake within 2 cycles
            end
            default:
            begin
               @(posedge clk_in);
               wfi <= 1'b1;
               @(posedge clk_in);
               wfi <= 1'b0;
               @(negedge clk_in);
            end
         endcase
         check_cause(irq_cause, e.exp_cause);
         check_pending(irq_pending, e.exp_pend);
         check_sleep(sleeping, e.exp_sleep);
         @(posedge clk_in);
         core_req      <= 1'b0;                         // Release after core_ack
         core_req_data <= '0;
      end

      total = rsp_errs + cause_errs + pend_errs + sleep_errs + mtime_errs + misc_errs;
      $display("Errors in %0d steps: rsp %0d cause %0d pend %0d sleep %0d mtime %0d other %0d",
               tbl.size(), rsp_errs, cause_errs, pend_errs, sleep_errs, mtime_errs, misc_errs);
      if (total == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Watchdog, budget scales with the table length
   initial
   begin
      wait (table_ready);
      repeat (8 + tbl.size() * CYC_PER_ENTRY) @(posedge clk_in);
      $display("Timeout: the table did not finish within %0d cycles",
               8 + tbl.size() * CYC_PER_ENTRY);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+tb
verilog/mmio_pkg.sv
verilog/ls_router.sv
verilog/mmr_timer.sv
verilog/irq_ctrl.sv
verilog/mmio_top.sv
tb/tb_mmio_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the MMIO slice testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_mmio_top -f flist.f -o tb_mmio_top \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_mmio_top | tee /dev/stderr | grep -q "All checks passed" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }
